// File: flist.f
+incdir+.
cpu_pkg.sv
decode_ctrl.sv
hazard_unit.sv
reg_file.sv
alu.sv
pipeline_cpu.sv
cpu_asserts.sv
tb_pipeline_cpu.sv

// File: Makefile
SIM := obj_dir/Vtb_pipeline_cpu

all: run

$(SIM): flist.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline_cpu -f flist.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb_pipeline_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_pipeline_cpu;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic [`CPU_XLEN-1:0] pcaddr;
    logic [`CPU_XLEN-1:0] inst;
    logic [`CPU_XLEN-1:0] rdata;
    cpu_pkg::dmem_req_t   dmem;

    logic [31:0] imem [256];
    logic [31:0] dmem_mem [256];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    logic [31:0] rng = 32'd37;
    int          prog_len;
    int          exp_count;
    int          exp_loads;
    int          seen;
    int          loads_seen;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          budget = 40;

    always #10 clk = ~clk;

    pipeline_cpu i_pipeline_cpu (
        .clk    (clk),
        .rst    (rst),
        .pcaddr (pcaddr),
        .inst   (inst),
        .dmem   (dmem),
        .rdata  (rdata)
    );

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    assign inst  = imem[pcaddr[9:2]];
    assign rdata = dmem.re ? dmem_mem[dmem.addr[9:2]] : '0;

    // Word store on the rising edge
    always @(posedge clk) begin
        if (dmem.we) begin
            dmem_mem[dmem.addr[9:2]] = dmem.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h1357_0000 ^ (idx * 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [25:0] idx);
        return {cpu_pkg::OP_J, idx};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // Jump to self with a nop in its delay slot
    task automatic close_program();
        emit(j_type(26'(prog_len)));
        emit(32'h0);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference interpreter stepping one instruction at a time
    ////////////////////////////////////////////////////////////

    function automatic int interpret_program(output int steps);
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] npc;
        logic [31:0] tgt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] ea;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wen;
        logic        done;
        int          n;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        pc        = `CPU_RESET_PC;
        npc       = pc + `CPU_PC_STEP;
        n         = 0;
        steps     = 0;
        exp_loads = 0;
        done      = 1'b0;
        while (!done && steps < 2000) begin
            w     = imem[pc[9:2]];
            a     = regs[w[25:21]];
            b     = regs[w[20:16]];
            sx    = {{16{w[15]}}, w[15:0]};
            ea    = a + sx;
            pc4   = pc + 32'd4;
            tgt   = npc + 32'd4;
            dst   = w[20:16];
            res   = '0;
            wen   = 1'b1;
            steps++;
            case (w[31:26])
                cpu_pkg::OP_SPECIAL: begin
                    dst = w[15:11];
                    case (w[5:0])
                        cpu_pkg::FN_ADD: res = a + b;
                        cpu_pkg::FN_SUB: res = a - b;
                        cpu_pkg::FN_AND: res = a & b;
                        cpu_pkg::FN_OR:  res = a | b;
                        cpu_pkg::FN_XOR: res = a ^ b;
                        cpu_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        cpu_pkg::FN_SLL: res = b << w[10:6];
                        cpu_pkg::FN_SRL: res = b >> w[10:6];
                        default:         wen = 1'b0;
                    endcase
                end
                cpu_pkg::OP_ADDI: res = a + sx;
                cpu_pkg::OP_ANDI: res = a & {16'h0, w[15:0]};
                cpu_pkg::OP_ORI:  res = a | {16'h0, w[15:0]};
                cpu_pkg::OP_LUI:  res = {w[15:0], 16'h0};
                cpu_pkg::OP_LW: begin
                    res = mem[ea[9:2]];
                    exp_loads++;
                end
                cpu_pkg::OP_SW: begin
                    wen = 1'b0;
                    mem[ea[9:2]] = b;
                    exp_addr[n] = ea;
                    exp_data[n] = b;
                    n++;
                end
                // Branch targets are relative to the delay slot
                cpu_pkg::OP_BEQ: begin
                    wen = 1'b0;
                    if (a == b) tgt = pc4 + (sx << 2);
                end
                cpu_pkg::OP_BNE: begin
                    wen = 1'b0;
                    if (a != b) tgt = pc4 + (sx << 2);
                end
                cpu_pkg::OP_J: begin
                    wen  = 1'b0;
                    tgt  = {pc4[31:28], w[25:0], 2'b00};
                    done = (tgt == pc);
                end
                default: wen = 1'b0;
            endcase
            if (wen && dst != 5'd0) begin
                regs[dst] = res;
            end
            pc  = npc;
            npc = tgt;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Programs
    ////////////////////////////////////////////////////////////

    task automatic alu_random_program();
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [15:0] off;
        off = 16'h0100;
        for (int r = 1; r <= 8; r++) begin
            rng = xorshift32(rng);
            d   = 5'(r);
            emit(i_type(cpu_pkg::OP_LUI, d, 5'd0, rng[31:16]));
            emit(i_type(cpu_pkg::OP_ORI, d, d, rng[15:0]));
        end
        for (int k = 0; k < 24; k++) begin
            rng = xorshift32(rng);
            d   = 5'd1 + {2'b00, rng[2:0]};
            s1  = 5'd1 + {2'b00, rng[5:3]};
            s2  = 5'd1 + {2'b00, rng[8:6]};
            case (rng[12:9])
                4'd0: emit(r_type(cpu_pkg::FN_ADD, d, s1, s2, 5'd0));
                4'd1: emit(r_type(cpu_pkg::FN_SUB, d, s1, s2, 5'd0));
                4'd2: emit(r_type(cpu_pkg::FN_AND, d, s1, s2, 5'd0));
                4'd3: emit(r_type(cpu_pkg::FN_OR, d, s1, s2, 5'd0));
                4'd4: emit(r_type(cpu_pkg::FN_XOR, d, s1, s2, 5'd0));
                4'd5: emit(r_type(cpu_pkg::FN_SLT, d, s1, s2, 5'd0));
                4'd6: emit(r_type(cpu_pkg::FN_SLL, d, 5'd0, s2, rng[17:13]));
                4'd7: emit(r_type(cpu_pkg::FN_SRL, d, 5'd0, s2, rng[17:13]));
                4'd8, 4'd9: emit(i_type(cpu_pkg::OP_ADDI, d, s1, rng[31:16]));
                4'd10, 4'd11: emit(i_type(cpu_pkg::OP_ANDI, d, s1, rng[31:16]));
                default: emit(i_type(cpu_pkg::OP_ORI, d, s1, rng[31:16]));
            endcase
            emit(i_type(cpu_pkg::OP_SW, d, 5'd0, off));
            off = off + 16'd4;
        end
    endtask

    // Producer to consumer distance of one, two and three
    task automatic dependency_chains();
        logic [15:0] off;
        off = 16'h0180;
        for (int d = 1; d <= 3; d++) begin
            for (int rep = 0; rep < 4; rep++) begin
                rng = xorshift32(rng);
                emit(i_type(cpu_pkg::OP_ADDI, 5'd1, 5'd1, rng[15:0]));
                for (int f = 1; f < d; f++) begin
                    emit(i_type(cpu_pkg::OP_ADDI, 5'd6, 5'd6, 16'd1));
                end
                if (rep % 2 == 1) begin
                    emit(r_type(cpu_pkg::FN_SUB, 5'd2, 5'd2, 5'd1, 5'd0));
                end else begin
                    emit(r_type(cpu_pkg::FN_ADD, 5'd2, 5'd1, 5'd2, 5'd0));
                end
                emit(i_type(cpu_pkg::OP_SW, 5'd2, 5'd0, off));
                off = off + 16'd4;
            end
        end
    endtask

    task automatic load_use_program();
        logic [15:0] off;
        off = 16'h0040;
        for (int rep = 0; rep < 4; rep++) begin
            rng = xorshift32(rng);
            emit(i_type(cpu_pkg::OP_LUI, 5'd3, 5'd0, rng[31:16]));
            emit(i_type(cpu_pkg::OP_ORI, 5'd3, 5'd3, rng[15:0]));
            emit(i_type(cpu_pkg::OP_SW, 5'd3, 5'd0, off));
            emit(i_type(cpu_pkg::OP_LW, 5'd4, 5'd0, off));
            emit(r_type(cpu_pkg::FN_ADD, 5'd5, 5'd4, 5'd3, 5'd0));
            emit(i_type(cpu_pkg::OP_SW, 5'd5, 5'd0, off + 16'd4));
            // Preloaded word goes straight back out as store data
            emit(i_type(cpu_pkg::OP_LW, 5'd6, 5'd0, off + 16'h0200));
            emit(i_type(cpu_pkg::OP_SW, 5'd6, 5'd0, off + 16'd8));
            off = off + 16'd16;
        end
    endtask

    task automatic branch_loop_program();
        emit(i_type(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'd4));
        emit(i_type(cpu_pkg::OP_ADDI, 5'd3, 5'd0, 16'd0));
        // Countdown loop at word 2
        emit(i_type(cpu_pkg::OP_ADDI, 5'd1, 5'd1, 16'hffff));
        emit(i_type(cpu_pkg::OP_SW, 5'd1, 5'd3, 16'h0200));
        emit(i_type(cpu_pkg::OP_BNE, 5'd0, 5'd1, 16'hfffd));
        emit(i_type(cpu_pkg::OP_ADDI, 5'd3, 5'd3, 16'd4));
        emit(i_type(cpu_pkg::OP_BEQ, 5'd0, 5'd0, 16'd2));
        emit(i_type(cpu_pkg::OP_ADDI, 5'd2, 5'd2, 16'd1));
        emit(i_type(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'h0300));
        emit(i_type(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0300));
        emit(j_type(26'd13));
        emit(i_type(cpu_pkg::OP_ADDI, 5'd2, 5'd2, 16'd5));
        emit(i_type(cpu_pkg::OP_SW, 5'd1, 5'd0, 16'h0304));
        emit(i_type(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0304));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////////////////////////

    // Program is loaded only while the DUT sits in reset
    task automatic start_test();
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
    endtask

    task automatic run_test(input string name);
        int steps;
        for (int i = 0; i < 256; i++) begin
            dmem_mem[i] = fill_word(i);
        end
        exp_count   = interpret_program(steps);
        seen        = 0;
        loads_seen  = 0;
        test_errors = 0;
        budget      = budget + 4 * steps + 40;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("first fetch address", pcaddr, `CPU_RESET_PC);
        wait (seen >= exp_count);
        repeat (8) @(posedge clk);
        check_value("load count", loads_seen, exp_loads);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s: %0d of %0d stores seen, %0d errors",
                 name, seen, exp_count, test_errors);
    endtask

    // Store checker
    always @(negedge clk) begin
        if (!rst && dmem.we) begin
            if (seen >= exp_count) begin
                $display("Unexpected store to address %h at %0t after all expected stores",
                         dmem.addr, $time);
                errors++;
                test_errors++;
            end else begin
                check_value("store address", dmem.addr, exp_addr[seen]);
                check_value("store data", dmem.wdata, exp_data[seen]);
            end
            seen++;
        end
    end

    // Every read strobe is one load leaving the memory stage
    always @(negedge clk) begin
        if (!rst && dmem.re) begin
            loads_seen++;
        end
    end

    // Budget grows with each test's instruction count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > budget) begin
            $display("Timeout: the DUT did not finish its stores within %0d cycles", budget);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            imem[i]     = '0;
            dmem_mem[i] = '0;
        end
        start_test();
        alu_random_program();
        close_program();
        run_test("alu_random");
        start_test();
        dependency_chains();
        close_program();
        run_test("dep_chains");
        start_test();
        load_use_program();
        close_program();
        run_test("load_use");
        start_test();
        branch_loop_program();
        close_program();
        run_test("branch_loop");
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: cpu_asserts.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic [`CPU_XLEN-1:0] pcaddr,
    input cpu_pkg::dmem_req_t   dmem
);

    // A single memory port never loads and stores in one cycle
    assert property (@(posedge clk) disable iff (rst) !(dmem.re && dmem.we))
        else $error("dmem read and write enables high together");

    assert property (@(posedge clk) disable iff (rst) pcaddr[1:0] == 2'b00)
        else $error("pcaddr is not word aligned");

    // Stage registers hold bubbles in reset
    assert property (@(posedge clk) rst |-> (!dmem.re && !dmem.we))
        else $error("dmem enable active during reset");

endmodule

bind pipeline_cpu cpu_asserts i_cpu_asserts (
    .clk    (clk),
    .rst    (rst),
    .pcaddr (pcaddr),
    .dmem   (dmem)
);

// File: pipeline_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module pipeline_cpu (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`CPU_XLEN-1:0] pcaddr,
    input  logic [`CPU_XLEN-1:0] inst,
    output cpu_pkg::dmem_req_t   dmem,
    input  logic [`CPU_XLEN-1:0] rdata
);

    logic [`CPU_XLEN-1:0]   pc;
    logic [`CPU_XLEN-1:0]   pc_plus4;
    logic [`CPU_XLEN-1:0]   next_pc;
    logic [`CPU_XLEN-1:0]   id_inst;
    logic [`CPU_XLEN-1:0]   id_pc4;
    logic [`CPU_REG_AW-1:0] rs;
    logic [`CPU_REG_AW-1:0] rt;
    logic [`CPU_REG_AW-1:0] rd;
    logic [4:0]             shamt;
    logic [15:0]            imm;
    logic [`CPU_XLEN-1:0]   imm_ext;
    logic [`CPU_XLEN-1:0]   br_target;
    logic [`CPU_XLEN-1:0]   j_target;
    logic                   br_taken;
    logic                   use_rs;
    logic                   use_rt;
    logic                   stall;
    logic [`CPU_XLEN-1:0]   rf_a;
    logic [`CPU_XLEN-1:0]   rf_b;
    logic [`CPU_XLEN-1:0]   opa;
    logic [`CPU_XLEN-1:0]   opb;
    logic [`CPU_XLEN-1:0]   alu_b;
    logic [`CPU_XLEN-1:0]   ex_result;
    logic [`CPU_XLEN-1:0]   wb_data;
    cpu_pkg::ctrl_t         ctrl;
    cpu_pkg::fwd_sel_e      fwd_a;
    cpu_pkg::fwd_sel_e      fwd_b;
    cpu_pkg::ex_stage_t     ex_d;
    cpu_pkg::ex_stage_t     ex_q;
    cpu_pkg::mem_stage_t    mem_d;
    cpu_pkg::mem_stage_t    mem_q;
    cpu_pkg::wb_stage_t     wb_d;
    cpu_pkg::wb_stage_t     wb_q;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e    sel,
        input logic [`CPU_XLEN-1:0] reg_val,
        input logic [`CPU_XLEN-1:0] ex_val,
        input logic [`CPU_XLEN-1:0] mem_val,
        input logic [`CPU_XLEN-1:0] load_val
    );
        case (sel)
            cpu_pkg::FWD_EX:   return ex_val;
            cpu_pkg::FWD_MEM:  return mem_val;
            cpu_pkg::FWD_LOAD: return load_val;
            default:           return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    assign pc_plus4 = pc + `CPU_PC_STEP;
    assign pcaddr   = pc;

    // Redirect takes effect after the delay slot already being fetched
    always_comb begin
        if (ctrl.jump) begin
            next_pc = j_target;
        end else if (br_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // PC and fetch register freeze on a load-use stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= `CPU_RESET_PC;
            id_inst <= '0;
            id_pc4  <= '0;
        end else if (!stall) begin
            pc      <= next_pc;
            id_inst <= inst;
            id_pc4  <= pc_plus4;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    assign rs    = id_inst[25:21];
    assign rt    = id_inst[20:16];
    assign rd    = id_inst[15:11];
    assign shamt = id_inst[10:6];
    assign imm   = id_inst[15:0];

    decode_ctrl i_decode_ctrl (
        .op    (cpu_pkg::opcode_e'(id_inst[31:26])),
        .funct (cpu_pkg::funct_e'(id_inst[5:0])),
        .ctrl  (ctrl)
    );

    assign use_rs = (ctrl.reg_write && !ctrl.sel_sa && ctrl.alu_op != cpu_pkg::ALU_LUI)
                    || ctrl.mem_write || ctrl.branch_eq || ctrl.branch_ne;
    assign use_rt = (ctrl.reg_write && !ctrl.sel_imm)
                    || ctrl.mem_write || ctrl.branch_eq || ctrl.branch_ne;

    hazard_unit i_hazard_unit (
        .rs        (rs),
        .rt        (rt),
        .use_rs    (use_rs),
        .use_rt    (use_rt),
        .ex_dest   (ex_q.dest),
        .mem_dest  (mem_q.dest),
        .ex_write  (ex_q.reg_write),
        .ex_load   (ex_q.mem_read),
        .mem_write (mem_q.reg_write),
        .mem_load  (mem_q.mem_read),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .stall     (stall)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rs),
        .raddr_b (rt),
        .waddr   (wb_q.dest),
        .wdata   (wb_data),
        .we      (wb_q.reg_write),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    assign opa = fwd_mux(fwd_a, rf_a, ex_result, mem_q.result, rdata);
    assign opb = fwd_mux(fwd_b, rf_b, ex_result, mem_q.result, rdata);

    assign imm_ext   = {{16{ctrl.sign_ext & imm[15]}}, imm};
    assign br_target = id_pc4 + {{14{imm[15]}}, imm, 2'b00};
    assign j_target  = {id_pc4[31:28], id_inst[25:0], 2'b00};
    assign br_taken  = (ctrl.branch_eq && opa == opb) || (ctrl.branch_ne && opa != opb);

    // Bubble into execute while stalled
    always_comb begin
        ex_d.a         = ctrl.sel_sa ? {{(`CPU_XLEN-5){1'b0}}, shamt} : opa;
        ex_d.b         = opb;
        ex_d.imm       = imm_ext;
        ex_d.dest      = ctrl.dest_rt ? rt : rd;
        ex_d.alu_op    = ctrl.alu_op;
        ex_d.sel_imm   = ctrl.sel_imm;
        ex_d.reg_write = ctrl.reg_write && !stall;
        ex_d.mem_read  = ctrl.mem_read && !stall;
        ex_d.mem_write = ctrl.mem_write && !stall;
    end

    ////////////////////////////////////////////////////////////
    // Execute, memory and write-back
    ////////////////////////////////////////////////////////////

    assign alu_b = ex_q.sel_imm ? ex_q.imm : ex_q.b;

    alu i_alu (
        .a      (ex_q.a),
        .b      (alu_b),
        .op     (ex_q.alu_op),
        .result (ex_result)
    );

    always_comb begin
        mem_d.result    = ex_result;
        mem_d.wdata     = ex_q.b;
        mem_d.dest      = ex_q.dest;
        mem_d.reg_write = ex_q.reg_write;
        mem_d.mem_read  = ex_q.mem_read;
        mem_d.mem_write = ex_q.mem_write;
    end

    assign dmem.addr  = mem_q.result;
    assign dmem.wdata = mem_q.wdata;
    assign dmem.re    = mem_q.mem_read;
    assign dmem.we    = mem_q.mem_write;

    always_comb begin
        wb_d.result    = mem_q.result;
        wb_d.load_data = rdata;
        wb_d.dest      = mem_q.dest;
        wb_d.reg_write = mem_q.reg_write;
        wb_d.mem_read  = mem_q.mem_read;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_q  <= '0;
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            ex_q  <= ex_d;
            mem_q <= mem_d;
            wb_q  <= wb_d;
        end
    end

    assign wb_data = wb_q.mem_read ? wb_q.load_data : wb_q.result;

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  cpu_pkg::alu_op_e     op,
    output logic [`CPU_XLEN-1:0] result
);

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_XOR: result = a ^ b;
            cpu_pkg::ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, less};
            // Shift amount arrives on a
            cpu_pkg::ALU_SLL: result = b << a[4:0];
            cpu_pkg::ALU_SRL: result = b >> a[4:0];
            cpu_pkg::ALU_LUI: result = b << 16;
            default:          result = '0;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_REG_AW-1:0] raddr_a,
    input  logic [`CPU_REG_AW-1:0] raddr_b,
    input  logic [`CPU_REG_AW-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]   wdata,
    input  logic                   we,
    output logic [`CPU_XLEN-1:0]   rdata_a,
    output logic [`CPU_XLEN-1:0]   rdata_b
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    // Written mid-cycle so decode sees the value in the same cycle
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module hazard_unit (
    input  logic [`CPU_REG_AW-1:0] rs,
    input  logic [`CPU_REG_AW-1:0] rt,
    input  logic                   use_rs,
    input  logic                   use_rt,
    input  logic [`CPU_REG_AW-1:0] ex_dest,
    input  logic [`CPU_REG_AW-1:0] mem_dest,
    input  logic                   ex_write,
    input  logic                   ex_load,
    input  logic                   mem_write,
    input  logic                   mem_load,
    output cpu_pkg::fwd_sel_e      fwd_a,
    output cpu_pkg::fwd_sel_e      fwd_b,
    output logic                   stall
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    // Register zero is hardwired and never forwards
    assign ex_hit_a  = use_rs && rs != '0 && ex_write && ex_dest == rs;
    assign ex_hit_b  = use_rt && rt != '0 && ex_write && ex_dest == rt;
    assign mem_hit_a = use_rs && rs != '0 && mem_write && mem_dest == rs;
    assign mem_hit_b = use_rt && rt != '0 && mem_write && mem_dest == rt;

    // Youngest producer wins
    function automatic cpu_pkg::fwd_sel_e pick(input logic ex_hit, input logic mem_hit);
        cpu_pkg::fwd_sel_e sel;
        if (ex_hit) begin
            sel = cpu_pkg::FWD_EX;
        end else if (mem_hit) begin
            sel = mem_load ? cpu_pkg::FWD_LOAD : cpu_pkg::FWD_MEM;
        end else begin
            sel = cpu_pkg::FWD_REG;
        end
        return sel;
    endfunction

    assign fwd_a = pick(ex_hit_a, mem_hit_a);
    assign fwd_b = pick(ex_hit_b, mem_hit_b);

    // Load data is not ready until the memory stage
    assign stall = ex_load && (ex_hit_a || ex_hit_b);

endmodule

// File: decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  cpu_pkg::opcode_e op,
    input  cpu_pkg::funct_e  funct,
    output cpu_pkg::ctrl_t   ctrl
);

    always_comb begin
        // Anything not recognized stays a bubble
        ctrl = '0;
        case (op)
            cpu_pkg::OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLL: begin
                        ctrl.alu_op = cpu_pkg::ALU_SLL;
                        ctrl.sel_sa = 1'b1;
                    end
                    cpu_pkg::FN_SRL: begin
                        ctrl.alu_op = cpu_pkg::ALU_SRL;
                        ctrl.sel_sa = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDI: begin
                ctrl.alu_op    = cpu_pkg::ALU_ADD;
                ctrl.sel_imm   = 1'b1;
                ctrl.sign_ext  = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_ANDI: begin
                ctrl.alu_op    = cpu_pkg::ALU_AND;
                ctrl.sel_imm   = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                ctrl.alu_op    = cpu_pkg::ALU_OR;
                ctrl.sel_imm   = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                ctrl.alu_op    = cpu_pkg::ALU_LUI;
                ctrl.sel_imm   = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // Loads and stores add a signed offset to rs
            cpu_pkg::OP_LW: begin
                ctrl.sel_imm   = 1'b1;
                ctrl.sign_ext  = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl.sel_imm   = 1'b1;
                ctrl.sign_ext  = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            cpu_pkg::OP_BEQ: ctrl.branch_eq = 1'b1;
            cpu_pkg::OP_BNE: ctrl.branch_ne = 1'b1;
            cpu_pkg::OP_J:   ctrl.jump      = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // Where a decode operand comes from
    typedef enum logic [1:0] {
        FWD_REG, FWD_EX, FWD_MEM, FWD_LOAD
    } fwd_sel_e;

    ////////////////////////////////////////////////////////////
    // Control and pipeline payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e alu_op;
        logic    sel_sa;
        logic    sel_imm;
        logic    sign_ext;
        logic    dest_rt;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
        logic                 re;
        logic                 we;
    } dmem_req_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   a;
        logic [`CPU_XLEN-1:0]   b;
        logic [`CPU_XLEN-1:0]   imm;
        logic [`CPU_REG_AW-1:0] dest;
        alu_op_e                alu_op;
        logic                   sel_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } ex_stage_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   result;
        logic [`CPU_XLEN-1:0]   wdata;
        logic [`CPU_REG_AW-1:0] dest;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
    } mem_stage_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   result;
        logic [`CPU_XLEN-1:0]   load_data;
        logic [`CPU_REG_AW-1:0] dest;
        logic                   reg_write;
        logic                   mem_read;
    } wb_stage_t;

endpackage

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and address width
`define CPU_XLEN 32

// Register file geometry
`define CPU_REG_COUNT 32
`define CPU_REG_AW 5

// Fetch sequencing
`define CPU_RESET_PC 32'h0000_0000
`define CPU_PC_STEP 32'd4

`endif
